// ==== hdl/fetch_settings.svh ====
`ifndef FETCH_SETTINGS_SVH
`define FETCH_SETTINGS_SVH

// Address of the first instruction fetched after reset
`define FETCH_RESET_PC 32'h3000_0000

// Number of direct-mapped lines, power of two
`define ICACHE_LINES 16

// 32-bit words per line, power of two
// Also sets the AXI burst length of a refill
`define ICACHE_LINE_WORDS 4

`endif

// ==== hdl/fetch_pkg.sv ====
`default_nettype none

`include "fetch_settings.svh"

package fetch_pkg;

    localparam int INDEX_W  = $clog2(`ICACHE_LINES);
    localparam int OFFSET_W = $clog2(`ICACHE_LINE_WORDS);
    // Two byte-offset bits below the word offset
    localparam int TAG_W    = 32 - INDEX_W - OFFSET_W - 2;

    typedef logic [31:0]         addr_t;
    typedef logic [31:0]         inst_t;
    typedef logic [INDEX_W-1:0]  line_index_t;
    typedef logic [OFFSET_W-1:0] word_offset_t;
    typedef logic [TAG_W-1:0]    tag_t;

    // Item handed to decode
    typedef struct packed {
        addr_t pc;
        inst_t inst;
        logic  error;
    } fetch_out_t;

    // Line-aligned address to fill
    typedef struct packed {
        addr_t base;
    } refill_req_t;

    // One refill word into the array
    typedef struct packed {
        line_index_t  index;
        word_offset_t offset;
        tag_t         tag;
        inst_t        data;
        logic         last;
    } refill_beat_t;

    typedef enum logic [1:0] {
        IDLE,
        LOOKUP,
        REFILL,
        HOLD
    } fetch_state_e;

    // ------------------------------------------------------------------------
    // Address field helpers
    // ------------------------------------------------------------------------
    function automatic line_index_t addr_index(addr_t addr);
        return addr[2 + OFFSET_W +: INDEX_W];
    endfunction

    function automatic word_offset_t addr_offset(addr_t addr);
        return addr[2 +: OFFSET_W];
    endfunction

    function automatic tag_t addr_tag(addr_t addr);
        return addr[31 -: TAG_W];
    endfunction

    function automatic addr_t line_base(addr_t addr);
        return {addr[31:2 + OFFSET_W], {(2 + OFFSET_W){1'b0}}};
    endfunction

endpackage

`default_nettype wire

// ==== hdl/fetch_control.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "fetch_settings.svh"

module fetch_control (
    input  wire                     clock,
    input  wire                     reset,
    input  wire                     redirect,
    input  wire fetch_pkg::addr_t   redirect_pc,
    input  wire                     flush,
    input  wire                     out_ready,
    input  wire                     hit,
    input  wire fetch_pkg::inst_t   hit_inst,
    input  wire                     refill_done,
    input  wire                     refill_error,
    output logic                    out_valid,
    output fetch_pkg::fetch_out_t   out_item,
    output logic                    lookup,
    output fetch_pkg::addr_t        lookup_addr,
    output logic                    invalidate_all,
    output logic                    refill_start,
    output fetch_pkg::refill_req_t  refill_req
);

    fetch_pkg::fetch_state_e state;
    fetch_pkg::addr_t        pc;
    fetch_pkg::addr_t        next_pc;
    logic                    flush_pending;
    logic                    flush_now;
    logic                    transfer;
    logic                    result_cycle;
    logic                    deliver_hit;
    logic                    deliver_error;

    assign transfer  = out_valid && out_ready;
    assign next_pc   = redirect ? redirect_pc : pc + 32'd4;
    // Flush seen now or earlier is applied at the next fetch start
    assign flush_now = flush_pending || flush;

    // Array answers one cycle after the lookup strobe
    assign result_cycle  = (state == fetch_pkg::LOOKUP) && !lookup;
    assign deliver_hit   = result_cycle && hit;
    assign deliver_error = (state == fetch_pkg::REFILL) && refill_done && refill_error;

    assign lookup_addr     = pc;
    assign refill_start    = result_cycle && !hit;
    assign refill_req.base = fetch_pkg::line_base(pc);

    // ------------------------------------------------------------------------
    // Fetch FSM
    // ------------------------------------------------------------------------
    always_ff @(posedge clock or posedge reset) begin
        if (reset) begin
            state          <= fetch_pkg::IDLE;
            pc             <= `FETCH_RESET_PC;
            lookup         <= 1'b0;
            invalidate_all <= 1'b0;
            out_valid      <= 1'b0;
            flush_pending  <= 1'b0;
        end else begin
            lookup         <= 1'b0;
            invalidate_all <= 1'b0;
            flush_pending  <= flush_now;
            case (state)
                fetch_pkg::IDLE: begin
                    lookup         <= 1'b1;
                    invalidate_all <= flush_now;
                    flush_pending  <= 1'b0;
                    state          <= fetch_pkg::LOOKUP;
                end
                fetch_pkg::LOOKUP: begin
                    if (deliver_hit) begin
                        out_valid <= 1'b1;
                        state     <= fetch_pkg::HOLD;
                    end else if (result_cycle) begin
                        state <= fetch_pkg::REFILL;
                    end
                end
                fetch_pkg::REFILL: begin
                    // Line is complete, so look it up again
                    if (deliver_error) begin
                        out_valid <= 1'b1;
                        state     <= fetch_pkg::HOLD;
                    end else if (refill_done) begin
                        lookup <= 1'b1;
                        state  <= fetch_pkg::LOOKUP;
                    end
                end
                fetch_pkg::HOLD: begin
                    // Accepted item starts the next fetch straight away
                    if (transfer) begin
                        out_valid      <= 1'b0;
                        pc             <= next_pc;
                        lookup         <= 1'b1;
                        invalidate_all <= flush_now;
                        flush_pending  <= 1'b0;
                        state          <= fetch_pkg::LOOKUP;
                    end
                end
                default: begin
                    state <= fetch_pkg::IDLE;
                end
            endcase
        end
    end

    // Output register for decode
    always_ff @(posedge clock) begin
        if (deliver_hit) begin
            out_item.pc    <= pc;
            out_item.inst  <= hit_inst;
            out_item.error <= 1'b0;
        end else if (deliver_error) begin
            out_item.pc    <= pc;
            out_item.inst  <= '0;
            out_item.error <= 1'b1;
        end
    end

    // ------------------------------------------------------------------------
    // Checks
    // ------------------------------------------------------------------------
    a_item_held: assert property (
        @(posedge clock) disable iff (reset)
        out_valid && !out_ready |=> out_valid && $stable(out_item)
    );

    // Refill only answers the lookup of the same address one cycle earlier
    a_refill_from_lookup: assert property (
        @(posedge clock) disable iff (reset)
        refill_start |-> $past(lookup) && $stable(lookup_addr)
    );

endmodule

`default_nettype wire

// ==== hdl/icache_array.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "fetch_settings.svh"

module icache_array (
    input  wire                      clock,
    input  wire                      reset,
    input  wire                      lookup,
    input  wire fetch_pkg::addr_t    lookup_addr,
    input  wire                      invalidate_all,
    input  wire                      beat_write,
    input  wire fetch_pkg::refill_beat_t beat,
    input  wire                      beat_error,
    output logic                     hit,
    output fetch_pkg::inst_t         hit_inst
);

    // ------------------------------------------------------------------------
    // Storage
    // ------------------------------------------------------------------------
    fetch_pkg::tag_t  line_tag   [`ICACHE_LINES];
    fetch_pkg::inst_t line_words [`ICACHE_LINES][`ICACHE_LINE_WORDS];
    logic [`ICACHE_LINES-1:0] line_valid;

    fetch_pkg::line_index_t  look_index;
    fetch_pkg::word_offset_t look_offset;
    fetch_pkg::tag_t         look_tag;
    logic                    tag_match;

    assign look_index  = fetch_pkg::addr_index(lookup_addr);
    assign look_offset = fetch_pkg::addr_offset(lookup_addr);
    assign look_tag    = fetch_pkg::addr_tag(lookup_addr);
    assign tag_match   = line_valid[look_index] && (line_tag[look_index] == look_tag);

    // Valid bits
    // Any refill beat drops the old line, the last clean beat makes it valid
    always_ff @(posedge clock or posedge reset) begin
        if (reset) begin
            line_valid <= '0;
        end else if (invalidate_all) begin
            line_valid <= '0;
        end else if (beat_write) begin
            line_valid[beat.index] <= beat.last && !beat_error;
        end
    end

    // ------------------------------------------------------------------------
    // Registered lookup
    // ------------------------------------------------------------------------
    // Invalidate in the same cycle wins over the old valid bit
    always_ff @(posedge clock or posedge reset) begin
        if (reset) begin
            hit <= 1'b0;
        end else begin
            hit <= lookup && tag_match && !invalidate_all;
        end
    end

    always_ff @(posedge clock) begin
        if (lookup) begin
            hit_inst <= line_words[look_index][look_offset];
        end
    end

    // Refill writes, one word per beat
    always_ff @(posedge clock) begin
        if (beat_write) begin
            line_tag[beat.index]               <= beat.tag;
            line_words[beat.index][beat.offset] <= beat.data;
        end
    end

    // Control must not look up while a line is being filled
    a_no_lookup_during_fill: assert property (
        @(posedge clock) disable iff (reset)
        !(lookup && beat_write)
    );

endmodule

`default_nettype wire

// ==== hdl/axi_refill_master.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "fetch_settings.svh"

module axi_refill_master (
    input  wire                          clock,
    input  wire                          reset,
    input  wire                          refill_start,
    input  wire fetch_pkg::refill_req_t  refill_req,
    input  wire                          arready,
    input  wire                          rvalid,
    input  wire [31:0]                   rdata,
    input  wire [1:0]                    rresp,
    input  wire                          rlast,
    input  wire [3:0]                    rid,
    output logic                         arvalid,
    output fetch_pkg::addr_t             araddr,
    output logic [3:0]                   arid,
    output logic [7:0]                   arlen,
    output logic [2:0]                   arsize,
    output logic [1:0]                   arburst,
    output logic                         rready,
    output logic                         beat_write,
    output fetch_pkg::refill_beat_t      beat,
    output logic                         beat_error,
    output logic                         refill_done,
    output logic                         refill_error
);

    logic                    busy;
    logic                    err_sticky;
    logic                    beat_bad;
    fetch_pkg::word_offset_t beat_offset;

    // ------------------------------------------------------------------------
    // AR channel, fixed burst shape
    // ------------------------------------------------------------------------
    assign arid    = 4'd0;
    assign arlen   = 8'(`ICACHE_LINE_WORDS - 1);
    // 4 bytes per beat, INCR
    assign arsize  = 3'b010;
    assign arburst = 2'b01;

    // R channel always accepted during a burst
    assign rready     = busy;
    assign beat_write = rvalid && rready;
    // Unexpected ID is treated like a bus error
    assign beat_bad   = (rresp != 2'b00) || (rid != arid);

    always_comb begin
        beat.index  = fetch_pkg::addr_index(araddr);
        beat.offset = beat_offset;
        beat.tag    = fetch_pkg::addr_tag(araddr);
        beat.data   = rdata;
        beat.last   = (beat_offset == '1);
    end

    // Error status includes the beat on the bus
    assign beat_error   = err_sticky || beat_bad;
    assign refill_done  = beat_write && beat.last;
    assign refill_error = beat_error;

    // ------------------------------------------------------------------------
    // Burst tracking
    // ------------------------------------------------------------------------
    always_ff @(posedge clock or posedge reset) begin
        if (reset) begin
            arvalid     <= 1'b0;
            busy        <= 1'b0;
            err_sticky  <= 1'b0;
            beat_offset <= '0;
        end else if (refill_start) begin
            arvalid     <= 1'b1;
            busy        <= 1'b1;
            err_sticky  <= 1'b0;
            beat_offset <= '0;
        end else begin
            if (arvalid && arready) begin
                arvalid <= 1'b0;
            end
            if (beat_write) begin
                beat_offset <= beat_offset + 1'b1;
                err_sticky  <= beat_error;
                if (beat.last) begin
                    busy <= 1'b0;
                end
            end
        end
    end

    // Line base held for the whole burst
    always_ff @(posedge clock) begin
        if (refill_start) begin
            araddr <= refill_req.base;
        end
    end

    // ------------------------------------------------------------------------
    // Checks
    // ------------------------------------------------------------------------
    a_ar_held: assert property (
        @(posedge clock) disable iff (reset)
        arvalid && !arready |=> arvalid && $stable(araddr)
    );

    a_rlast_on_line_end: assert property (
        @(posedge clock) disable iff (reset)
        beat_write |-> (rlast == beat.last)
    );

endmodule

`default_nettype wire

// ==== hdl/fetch_top.sv ====
`timescale 1ns/1ps
`default_nettype none

module fetch_top (
    input  wire                         clock,
    input  wire                         reset,
    // Branch and cache control
    input  wire                         redirect,
    input  wire fetch_pkg::addr_t       redirect_pc,
    input  wire                         flush,
    // Decode side
    output logic                        out_valid,
    output fetch_pkg::fetch_out_t       out_item,
    input  wire                         out_ready,
    // AXI4 read address
    output logic                        arvalid,
    input  wire                         arready,
    output fetch_pkg::addr_t            araddr,
    output logic [3:0]                  arid,
    output logic [7:0]                  arlen,
    output logic [2:0]                  arsize,
    output logic [1:0]                  arburst,
    // AXI4 read data
    input  wire                         rvalid,
    output logic                        rready,
    input  wire [31:0]                  rdata,
    input  wire [1:0]                   rresp,
    input  wire                         rlast,
    input  wire [3:0]                   rid
);

    // ------------------------------------------------------------------------
    // Internal links
    // ------------------------------------------------------------------------
    logic                    lookup;
    fetch_pkg::addr_t        lookup_addr;
    logic                    hit;
    fetch_pkg::inst_t        hit_inst;
    logic                    invalidate_all;
    logic                    refill_start;
    fetch_pkg::refill_req_t  refill_req;
    logic                    refill_done;
    logic                    refill_error;
    logic                    beat_write;
    fetch_pkg::refill_beat_t beat;
    logic                    beat_error;

    fetch_control i_control (
        .clock          (clock),
        .reset          (reset),
        .redirect       (redirect),
        .redirect_pc    (redirect_pc),
        .flush          (flush),
        .out_ready      (out_ready),
        .hit            (hit),
        .hit_inst       (hit_inst),
        .refill_done    (refill_done),
        .refill_error   (refill_error),
        .out_valid      (out_valid),
        .out_item       (out_item),
        .lookup         (lookup),
        .lookup_addr    (lookup_addr),
        .invalidate_all (invalidate_all),
        .refill_start   (refill_start),
        .refill_req     (refill_req)
    );

    icache_array i_array (
        .clock          (clock),
        .reset          (reset),
        .lookup         (lookup),
        .lookup_addr    (lookup_addr),
        .invalidate_all (invalidate_all),
        .beat_write     (beat_write),
        .beat           (beat),
        .beat_error     (beat_error),
        .hit            (hit),
        .hit_inst       (hit_inst)
    );

    axi_refill_master i_refill (
        .clock          (clock),
        .reset          (reset),
        .refill_start   (refill_start),
        .refill_req     (refill_req),
        .arready        (arready),
        .rvalid         (rvalid),
        .rdata          (rdata),
        .rresp          (rresp),
        .rlast          (rlast),
        .rid            (rid),
        .arvalid        (arvalid),
        .araddr         (araddr),
        .arid           (arid),
        .arlen          (arlen),
        .arsize         (arsize),
        .arburst        (arburst),
        .rready         (rready),
        .beat_write     (beat_write),
        .beat           (beat),
        .beat_error     (beat_error),
        .refill_done    (refill_done),
        .refill_error   (refill_error)
    );

endmodule

`default_nettype wire

// ==== dv/axi_mem_model.sv ====
`timescale 1ns/1ps
`default_nettype none

module axi_mem_model #(
    parameter int ERROR_BIT = 27
) (
    input  wire         clock,
    input  wire         reset,
    input  wire  [31:0] generation,
    input  wire         arvalid,
    output logic        arready,
    input  wire  [31:0] araddr,
    input  wire  [3:0]  arid,
    input  wire  [7:0]  arlen,
    output logic        rvalid,
    input  wire         rready,
    output logic [31:0] rdata,
    output logic [1:0]  rresp,
    output logic        rlast,
    output logic [3:0]  rid
);

    integer      seed = 32'h7204;
    logic        in_burst;
    logic [31:0] beat_addr;
    int          beats_left;
    logic        ar_done;
    logic        r_done;
    logic [31:0] ar_addr_seen;
    logic [7:0]  ar_len_seen;
    logic [3:0]  ar_id_seen;

    // Handshakes sampled on the edge, responses driven just after it
    initial begin
        arready    = 1'b0;
        rvalid     = 1'b0;
        rdata      = '0;
        rresp      = 2'b00;
        rlast      = 1'b0;
        rid        = '0;
        in_burst   = 1'b0;
        beat_addr  = '0;
        beats_left = 0;
        forever begin
            @(posedge clock);
            ar_done      = arvalid && arready;
            r_done       = rvalid && rready;
            ar_addr_seen = araddr;
            ar_len_seen  = arlen;
            ar_id_seen   = arid;
            #1;
            if (reset) begin
                arready  = 1'b0;
                rvalid   = 1'b0;
                in_burst = 1'b0;
            end else begin
                if (ar_done) begin
                    in_burst   = 1'b1;
                    beat_addr  = ar_addr_seen;
                    beats_left = ar_len_seen + 1;
                    rid        = ar_id_seen;
                end
                if (r_done) begin
                    rvalid     = 1'b0;
                    beat_addr  = beat_addr + 32'd4;
                    beats_left = beats_left - 1;
                    if (beats_left == 0) begin
                        in_burst = 1'b0;
                    end
                end
                // One burst at a time, random AR stalls
                arready = !in_burst && (($random(seed) & 3) != 0);
                // A presented beat holds until rready
                if (in_burst && !rvalid && (($random(seed) & 3) != 0)) begin
                    rvalid = 1'b1;
                    rlast  = (beats_left == 1);
                    if (beat_addr[ERROR_BIT]) begin
                        rdata = '0;
                        rresp = 2'b10;
                    end else begin
                        rdata = beat_addr ^ generation;
                        rresp = 2'b00;
                    end
                end
            end
        end
    end

endmodule

`default_nettype wire

// ==== dv/tb_fetch_top.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "fetch_settings.svh"

module tb_fetch_top;

    // Error region on bit 27 lies clear of the reset PC region
    localparam int ERROR_BIT   = 27;
    localparam int TOTAL_ITEMS = 80;
    localparam int CYCLE_LIMIT = 200 * TOTAL_ITEMS;
    localparam int VALUE_W     = $bits(fetch_pkg::fetch_out_t);
    localparam logic [31:0] LINE_BYTES = `ICACHE_LINE_WORDS * 4;
    localparam logic [31:0] GEN_A = 32'h1357_9bdf;
    localparam logic [31:0] GEN_B = 32'h2468_ace0;

    logic                  clock;
    logic                  reset;
    logic                  redirect;
    fetch_pkg::addr_t      redirect_pc;
    logic                  flush;
    logic                  out_valid;
    fetch_pkg::fetch_out_t out_item;
    logic                  out_ready;
    logic                  arvalid;
    logic                  arready;
    fetch_pkg::addr_t      araddr;
    logic [3:0]            arid;
    logic [7:0]            arlen;
    logic [2:0]            arsize;
    logic [1:0]            arburst;
    logic                  rvalid;
    logic                  rready;
    logic [31:0]           rdata;
    logic [1:0]            rresp;
    logic                  rlast;
    logic [3:0]            rid;
    logic [31:0]           generation;

    integer                seed = 32'h7204;
    int                    accepted;
    int                    error_count;
    int                    cycle_count;
    int                    test_errors_at_start;
    int                    test_items_at_start;
    string                 test_name;
    fetch_pkg::addr_t      exp_pc;
    logic [31:0]           exp_gen;
    logic                  held;
    fetch_pkg::fetch_out_t held_item;

    fetch_top i_dut (
        .clock       (clock),
        .reset       (reset),
        .redirect    (redirect),
        .redirect_pc (redirect_pc),
        .flush       (flush),
        .out_valid   (out_valid),
        .out_item    (out_item),
        .out_ready   (out_ready),
        .arvalid     (arvalid),
        .arready     (arready),
        .araddr      (araddr),
        .arid        (arid),
        .arlen       (arlen),
        .arsize      (arsize),
        .arburst     (arburst),
        .rvalid      (rvalid),
        .rready      (rready),
        .rdata       (rdata),
        .rresp       (rresp),
        .rlast       (rlast),
        .rid         (rid)
    );

    axi_mem_model #(.ERROR_BIT(ERROR_BIT)) i_mem (
        .clock      (clock),
        .reset      (reset),
        .generation (generation),
        .arvalid    (arvalid),
        .arready    (arready),
        .araddr     (araddr),
        .arid       (arid),
        .arlen      (arlen),
        .rvalid     (rvalid),
        .rready     (rready),
        .rdata      (rdata),
        .rresp      (rresp),
        .rlast      (rlast),
        .rid        (rid)
    );

    initial begin
        clock = 1'b0;
        forever #4 clock = ~clock;
    end

    // ------------------------------------------------------------------------
    // Reference model and checking
    // ------------------------------------------------------------------------
    function automatic fetch_pkg::fetch_out_t expected_item(fetch_pkg::addr_t pc,
                                                            logic [31:0] gen);
        fetch_pkg::fetch_out_t item;
        item.pc = pc;
        if (pc[ERROR_BIT]) begin
            item.inst  = '0;
            item.error = 1'b1;
        end else begin
            item.inst  = pc ^ gen;
            item.error = 1'b0;
        end
        return item;
    endfunction

    task automatic check_value(input string name, input logic [VALUE_W-1:0] expected,
                               input logic [VALUE_W-1:0] actual);
        if (actual !== expected) begin
            $display("FAILED %s: expected %h, actual %h", name, expected, actual);
            error_count++;
        end
    endtask

    // Every transfer and every held cycle is checked on the clock edge
    always @(posedge clock) begin
        if (reset) begin
            check_value("reset out_valid", 1'b0, out_valid);
            check_value("reset arvalid", 1'b0, arvalid);
        end else begin
            // Line fill request for the item still to come
            if (arvalid && arready) begin
                check_value({test_name, " araddr"}, exp_pc & ~(LINE_BYTES - 1), araddr);
                check_value({test_name, " arlen"}, `ICACHE_LINE_WORDS - 1, arlen);
                check_value({test_name, " arsize"}, 3'b010, arsize);
                check_value({test_name, " arburst"}, 2'b01, arburst);
                check_value({test_name, " arid"}, 4'd0, arid);
            end
            if (held) begin
                if (!out_valid) begin
                    $display("%s: out_valid dropped while decode held the item", test_name);
                    error_count++;
                end
                check_value({test_name, " (held)"}, held_item, out_item);
            end
            if (out_valid && out_ready) begin
                check_value(test_name, expected_item(exp_pc, exp_gen), out_item);
                accepted++;
                exp_pc  = redirect ? redirect_pc : exp_pc + 32'd4;
                exp_gen = generation;
            end
            held      = out_valid && !out_ready;
            held_item = out_item;
        end
    end

    initial begin
        cycle_count = 0;
        while (cycle_count < CYCLE_LIMIT) begin
            @(posedge clock);
            cycle_count++;
        end
        $display("Timeout after %0d cycles, %0d of %0d items accepted",
                 cycle_count, accepted, TOTAL_ITEMS);
        $display("Simulation finished: FAIL");
        $finish;
    end

    // ------------------------------------------------------------------------
    // Stimulus helpers
    // ------------------------------------------------------------------------
    // Redirect, if any, rides on the first transfer of the batch
    task automatic fetch_items(input int count, input int stall_pct, input logic jump,
                               input fetch_pkg::addr_t target);
        int start;
        start = accepted;
        while (accepted - start < count) begin
            redirect    = jump && (accepted == start);
            redirect_pc = target;
            out_ready   = (($unsigned($random(seed)) % 100) >= stall_pct);
            @(posedge clock);
            #1;
        end
        out_ready = 1'b0;
        redirect  = 1'b0;
    endtask

    task automatic start_test(input string name);
        test_name            = name;
        test_errors_at_start = error_count;
        test_items_at_start  = accepted;
    endtask

    task automatic report_test();
        $display("test %-12s %0d items, %0d errors", test_name,
                 accepted - test_items_at_start, error_count - test_errors_at_start);
    endtask

    // ------------------------------------------------------------------------
    // Test sequence
    // ------------------------------------------------------------------------
    initial begin
        reset       = 1'b1;
        redirect    = 1'b0;
        redirect_pc = '0;
        flush       = 1'b0;
        out_ready   = 1'b0;
        generation  = GEN_A;
        accepted    = 0;
        error_count = 0;
        exp_pc      = `FETCH_RESET_PC;
        exp_gen     = GEN_A;
        held        = 1'b0;
        held_item   = '0;
        test_name   = "reset";
        repeat (8) @(posedge clock);
        #1;
        reset = 1'b0;

        start_test("sequential");
        fetch_items(20, 0, 1'b0, '0);
        report_test();

        // Second jump lands in line 3 which is still cached from the first test
        start_test("redirect");
        fetch_items(8, 0, 1'b1, 32'h3000_0104);
        fetch_items(6, 0, 1'b1, 32'h3000_0034);
        report_test();

        start_test("backpressure");
        fetch_items(24, 50, 1'b1, 32'h3000_0200);
        report_test();

        // New memory contents while the FSM holds an item and no refill runs
        start_test("flush");
        while (!out_valid) begin
            @(posedge clock);
            #1;
        end
        generation = GEN_B;
        flush      = 1'b1;
        @(posedge clock);
        #1;
        flush = 1'b0;
        fetch_items(12, 0, 1'b1, 32'h3000_0200);
        report_test();

        start_test("error_region");
        fetch_items(4, 0, 1'b1, 32'h3800_0010);
        fetch_items(6, 0, 1'b1, 32'h3000_0000);
        report_test();

        $display("Summary: %0d items checked, %0d errors", accepted, error_count);
        if (error_count == 0) begin
            $display("Simulation finished: PASS");
        end else begin
            $display("Simulation finished: FAIL");
        end
        $finish;
    end

endmodule

`default_nettype wire

// ==== verilog.f ====
+incdir+hdl
hdl/fetch_pkg.sv
hdl/fetch_control.sv
hdl/icache_array.sv
hdl/axi_refill_master.sv
hdl/fetch_top.sv
dv/axi_mem_model.sv
dv/tb_fetch_top.sv
